/* logic/icache_addr_pkg.sv */
// ------------------------------
// Address field widths, field types and field extraction
// ------------------------------
`include "icache_defines.svh"

package icache_addr_pkg;

    // Field widths, byte offset at the bottom
    localparam int BYTE_W  = $clog2(`ICACHE_DATA_WIDTH / 8);
    localparam int OFF_W   = $clog2(`ICACHE_WORDS_PER_LINE);
    localparam int INDEX_W = $clog2(`ICACHE_SETS);
    localparam int TAG_W   = `ICACHE_ADDR_WIDTH - INDEX_W - OFF_W - BYTE_W;

    typedef logic [TAG_W-1:0]                tag_t;
    typedef logic [INDEX_W-1:0]              index_t;
    typedef logic [OFF_W-1:0]                word_off_t;
    typedef logic [`ICACHE_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`ICACHE_DATA_WIDTH-1:0]   word_t;

    // Field pickers
    function automatic tag_t addr_tag(addr_t a);
        return a[`ICACHE_ADDR_WIDTH-1 -: TAG_W];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[BYTE_W + OFF_W +: INDEX_W];
    endfunction

    function automatic word_off_t addr_off(addr_t a);
        return a[BYTE_W +: OFF_W];
    endfunction

endpackage

/* logic/icache_ctrl_pkg.sv */
// ------------------------------
// Controller state enum and way number type
// ------------------------------
`include "icache_defines.svh"

package icache_ctrl_pkg;

    // One bit for two ways
    typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;

    // Miss controller states
    typedef enum logic [2:0] {
        // Accepts requests, answers hits
        S_IDLE,
        // Line request offered to memory
        S_MISS_REQ,
        // Taking response beats
        S_FILL,
        // Missed word returned
        S_RESPOND,
        // One cycle valid clear
        S_FLUSH
    } miss_state_e;

endpackage

/* logic/icache_data_array.sv */
// ------------------------------
// Line data storage, fill writes, read word mux
// ------------------------------
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_data_array (
    input  logic                      clk_i,
    input  icache_addr_pkg::addr_t    lookup_addr_i,
    input  icache_ctrl_pkg::way_t     hit_way_i,
    input  logic                      fill_we_i,
    input  icache_ctrl_pkg::way_t     fill_way_i,
    input  icache_addr_pkg::word_off_t fill_off_i,
    input  icache_addr_pkg::word_t    fill_data_i,
    output icache_addr_pkg::word_t    rd_data_o
);
    import icache_addr_pkg::*;

    // Words by way, set and offset
    word_t mem_q [`ICACHE_WAYS][`ICACHE_SETS][`ICACHE_WORDS_PER_LINE];

    index_t    idx;
    word_off_t off;

    assign idx = addr_index(lookup_addr_i);
    assign off = addr_off(lookup_addr_i);

    // ------------------------------
    // Fill
    // ------------------------------
    // One beat per write, set from the latched miss address
    always_ff @(posedge clk_i) begin
        if (fill_we_i) begin
            mem_q[fill_way_i][idx][fill_off_i] <= fill_data_i;
        end
    end

    // ------------------------------
    // Read
    // ------------------------------
    // Combinational, way from tag compare
    assign rd_data_o = mem_q[hit_way_i][idx][off];

endmodule

/* logic/icache_defines.svh */
// ------------------------------
// Cache geometry and counter width macros
// ------------------------------
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Byte address width of the fetch path
`define ICACHE_ADDR_WIDTH 32

// One instruction word
`define ICACHE_DATA_WIDTH 32

// Two-way, 16 sets
`define ICACHE_SETS 16
`define ICACHE_WAYS 2

// Line of 4 words, 16 bytes
`define ICACHE_WORDS_PER_LINE 4

// Hit and miss counter width
`define ICACHE_PERF_WIDTH 32

`endif

/* logic/icache_miss_ctrl.sv */
// ------------------------------
// Miss FSM, request latch, line fetch,
// fill beat count, CPU response and flush
// ------------------------------
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_miss_ctrl (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       cpu_req_valid_i,
    input  icache_addr_pkg::addr_t     cpu_req_addr_i,
    input  logic                       hit_i,
    input  icache_ctrl_pkg::way_t      victim_way_i,
    input  logic                       mem_req_ready_i,
    input  logic                       mem_rsp_valid_i,
    input  logic                       flush_i,
    output logic                       cpu_req_ready_o,
    output logic                       cpu_rsp_valid_o,
    output logic                       cpu_rsp_hit_o,
    output icache_addr_pkg::addr_t     lookup_addr_o,
    output logic                       mem_req_valid_o,
    output icache_addr_pkg::addr_t     mem_req_addr_o,
    output logic                       fill_we_o,
    output icache_ctrl_pkg::way_t      fill_way_o,
    output icache_addr_pkg::word_off_t fill_off_o,
    output logic                       tag_we_o,
    output logic                       flush_clear_o,
    output logic                       flush_done_o,
    output logic                       hit_evt_o,
    output logic                       miss_evt_o
);
    import icache_addr_pkg::*;
    import icache_ctrl_pkg::*;

    miss_state_e state_q, state_d;
    addr_t       req_addr_q;
    way_t        fill_way_q;
    word_off_t   beat_q;
    logic        accept;
    logic        last_beat;

    // ------------------------------
    // Handshake and strobes
    // ------------------------------
    // Flush wins over a request in idle
    assign cpu_req_ready_o = (state_q == S_IDLE) && !flush_i;
    assign accept          = cpu_req_valid_i && cpu_req_ready_o;

    // Live address in idle, latched miss address otherwise
    assign lookup_addr_o = (state_q == S_IDLE) ? cpu_req_addr_i : req_addr_q;

    // Hit answers at once; miss answers from S_RESPOND
    assign cpu_rsp_valid_o = (accept && hit_i) || (state_q == S_RESPOND);
    assign cpu_rsp_hit_o   = (state_q == S_IDLE) && hit_i;

    assign hit_evt_o  = accept && hit_i;
    assign miss_evt_o = accept && !hit_i;

    // Line base, offset and byte bits zero
    assign mem_req_valid_o = (state_q == S_MISS_REQ);
    assign mem_req_addr_o  = {addr_tag(req_addr_q), addr_index(req_addr_q),
                              {(OFF_W + BYTE_W){1'b0}}};

    // Beats arrive in ascending offset order
    assign fill_we_o  = (state_q == S_FILL) && mem_rsp_valid_i;
    assign fill_way_o = fill_way_q;
    assign fill_off_o = beat_q;
    assign last_beat  = (beat_q == word_off_t'(`ICACHE_WORDS_PER_LINE - 1));
    assign tag_we_o   = fill_we_o && last_beat;

    assign flush_clear_o = (state_q == S_FLUSH);
    assign flush_done_o  = (state_q == S_FLUSH);

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (flush_i) begin
                    state_d = S_FLUSH;
                end else if (accept && !hit_i) begin
                    state_d = S_MISS_REQ;
                end
            end
            S_MISS_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = S_FILL;
                end
            end
            S_FILL: begin
                if (tag_we_o) begin
                    state_d = S_RESPOND;
                end
            end
            S_RESPOND: state_d = S_IDLE;
            S_FLUSH:   state_d = S_IDLE;
            default:   state_d = S_IDLE;
        endcase
    end

    // ------------------------------
    // Registers
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= S_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (miss_evt_o) begin
                beat_q <= '0;
            end else if (fill_we_o) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // Miss address and victim held for the whole fill
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_addr_q <= cpu_req_addr_i;
            fill_way_q <= victim_way_i;
        end
    end

endmodule

/* logic/icache_perf_counters.sv */
// ------------------------------
// Hit and miss event counters
// ------------------------------
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_perf_counters (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          hit_evt_i,
    input  logic                          miss_evt_i,
    output logic [`ICACHE_PERF_WIDTH-1:0] perf_hit_count_o,
    output logic [`ICACHE_PERF_WIDTH-1:0] perf_miss_count_o
);

    // Both wrap at full scale
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            perf_hit_count_o  <= '0;
            perf_miss_count_o <= '0;
        end else begin
            if (hit_evt_i) begin
                perf_hit_count_o <= perf_hit_count_o + 1'b1;
            end
            // Counted on acceptance, not on fill
            if (miss_evt_i) begin
                perf_miss_count_o <= perf_miss_count_o + 1'b1;
            end
        end
    end

endmodule

/* logic/icache_tag_array.sv */
// ------------------------------
// Valid and tag storage, two-way lookup,
// round-robin victim pointers and flush clear
// ------------------------------
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_tag_array (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  icache_addr_pkg::addr_t lookup_addr_i,
    input  logic                   tag_we_i,
    input  logic                   flush_clear_i,
    output logic                   hit_o,
    output icache_ctrl_pkg::way_t  hit_way_o,
    output icache_ctrl_pkg::way_t  victim_way_o
);
    import icache_addr_pkg::*;
    import icache_ctrl_pkg::*;

    // Storage per way and set
    logic   valid_q [`ICACHE_WAYS][`ICACHE_SETS];
    tag_t   tag_q   [`ICACHE_WAYS][`ICACHE_SETS];
    // Next way to replace, per set
    way_t   victim_q [`ICACHE_SETS];

    index_t                  idx;
    tag_t                    tag;
    logic [`ICACHE_WAYS-1:0] way_hit;

    assign idx = addr_index(lookup_addr_i);
    assign tag = addr_tag(lookup_addr_i);

    // ------------------------------
    // Lookup
    // ------------------------------
    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == tag);
        end
    end

    assign hit_o = |way_hit;

    // Encode hitting way, at most one is set
    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way_o = way_t'(w);
            end
        end
    end

    assign victim_way_o = victim_q[idx];

    // ------------------------------
    // Valid bits and victim pointers
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    valid_q[w][s] <= 1'b0;
                end
                victim_q[s] <= '0;
            end
        end else if (flush_clear_i) begin
            // Whole cache invalid, pointers kept
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    valid_q[w][s] <= 1'b0;
                end
            end
        end else if (tag_we_i) begin
            valid_q[victim_q[idx]][idx] <= 1'b1;
            // Advance to the other way
            victim_q[idx] <= victim_q[idx] + 1'b1;
        end
    end

    // Tag written with the last fill beat
    always_ff @(posedge clk_i) begin
        if (tag_we_i) begin
            tag_q[victim_q[idx]][idx] <= tag;
        end
    end

endmodule

/* logic/icache_top.sv */
// ------------------------------
// Cache top, arrays, controller and counters
// ------------------------------
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_top (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    // CPU fetch side
    input  logic                          cpu_req_valid_i,
    input  icache_addr_pkg::addr_t        cpu_req_addr_i,
    output logic                          cpu_req_ready_o,
    output logic                          cpu_rsp_valid_o,
    output icache_addr_pkg::word_t        cpu_rsp_data_o,
    output logic                          cpu_rsp_hit_o,
    // Memory side
    output logic                          mem_req_valid_o,
    output icache_addr_pkg::addr_t        mem_req_addr_o,
    input  logic                          mem_req_ready_i,
    input  logic                          mem_rsp_valid_i,
    input  icache_addr_pkg::word_t        mem_rsp_data_i,
    // Flush
    input  logic                          flush_i,
    output logic                          flush_done_o,
    // Counters
    output logic [`ICACHE_PERF_WIDTH-1:0] perf_hit_count_o,
    output logic [`ICACHE_PERF_WIDTH-1:0] perf_miss_count_o
);
    import icache_addr_pkg::*;
    import icache_ctrl_pkg::*;

    addr_t     lookup_addr;
    logic      hit;
    way_t      hit_way;
    way_t      victim_way;
    logic      fill_we;
    way_t      fill_way;
    word_off_t fill_off;
    logic      tag_we;
    logic      flush_clear;
    logic      hit_evt;
    logic      miss_evt;

    icache_tag_array u_tag_array (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .lookup_addr_i (lookup_addr),
        .tag_we_i      (tag_we),
        .flush_clear_i (flush_clear),
        .hit_o         (hit),
        .hit_way_o     (hit_way),
        .victim_way_o  (victim_way)
    );

    // Response word always comes from the array
    icache_data_array u_data_array (
        .clk_i         (clk_i),
        .lookup_addr_i (lookup_addr),
        .hit_way_i     (hit_way),
        .fill_we_i     (fill_we),
        .fill_way_i    (fill_way),
        .fill_off_i    (fill_off),
        .fill_data_i   (mem_rsp_data_i),
        .rd_data_o     (cpu_rsp_data_o)
    );

    icache_miss_ctrl u_miss_ctrl (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .cpu_req_valid_i (cpu_req_valid_i),
        .cpu_req_addr_i  (cpu_req_addr_i),
        .hit_i           (hit),
        .victim_way_i    (victim_way),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .flush_i         (flush_i),
        .cpu_req_ready_o (cpu_req_ready_o),
        .cpu_rsp_valid_o (cpu_rsp_valid_o),
        .cpu_rsp_hit_o   (cpu_rsp_hit_o),
        .lookup_addr_o   (lookup_addr),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .fill_we_o       (fill_we),
        .fill_way_o      (fill_way),
        .fill_off_o      (fill_off),
        .tag_we_o        (tag_we),
        .flush_clear_o   (flush_clear),
        .flush_done_o    (flush_done_o),
        .hit_evt_o       (hit_evt),
        .miss_evt_o      (miss_evt)
    );

    icache_perf_counters u_perf_counters (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .hit_evt_i         (hit_evt),
        .miss_evt_i        (miss_evt),
        .perf_hit_count_o  (perf_hit_count_o),
        .perf_miss_count_o (perf_miss_count_o)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the cache testbench with Verilator, run it, and scan the log
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert --top-module icache_tb -f vlog.f -o icache_sim \
    > "$LOG" 2>&1 &&
    ./obj_dir/icache_sim >> "$LOG" 2>&1 ||
    echo "Simulation finished: FAIL" >> "$LOG"
cat "$LOG"
grep -q "Simulation finished: FAIL" "$LOG" && exit 1 || exit 0

/* verification/icache_tb.sv */
// ------------------------------
// Cache testbench with memory model, reference model,
// concurrent checks, watchdog and report
// ------------------------------
`timescale 1ns/1ns

module icache_tb;

    localparam int          CLK_PERIOD  = 40;
    localparam int          MISS_CYCLES = 20;
    localparam int          RAND_N      = 48;
    // Accesses over all tests
    localparam int          N_ACCESS    = 1 + 4 + RAND_N + 4;
    // Reset, accesses at the longest miss, flush, margin
    localparam int          RUN_CYCLES  = 10 + N_ACCESS * (MISS_CYCLES + 2) + 60;
    localparam logic [31:0] WORD_MASK   = 32'hA5A5_0000;

    logic        clk_i;
    logic        rst_ni;
    logic        cpu_req_valid_i;
    logic [31:0] cpu_req_addr_i;
    logic        cpu_req_ready_o;
    logic        cpu_rsp_valid_o;
    logic [31:0] cpu_rsp_data_o;
    logic        cpu_rsp_hit_o;
    logic        mem_req_valid_o;
    logic [31:0] mem_req_addr_o;
    logic        mem_req_ready_i;
    logic        mem_rsp_valid_i;
    logic [31:0] mem_rsp_data_i;
    logic        flush_i;
    logic        flush_done_o;
    logic [31:0] perf_hit_count_o;
    logic [31:0] perf_miss_count_o;

    // Expectations, all changed on falling edges
    logic        hit_due;
    logic        fill_due;
    logic        flush_due;
    logic        miss_pending;
    logic        after_reset;
    logic        cnt_check;
    logic [31:0] exp_data;
    logic [31:0] exp_line;
    logic [31:0] n_hit;
    logic [31:0] n_miss;
    int          assert_errors = 0;
    int          fault_count   = 0;
    int          tests_run     = 0;

    // Reference model, tag is addr[31:8], set is addr[7:4]
    logic        ref_valid [2][16];
    logic [23:0] ref_tag   [2][16];
    logic        ref_ptr   [16];

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    icache_top UUT (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .cpu_req_valid_i   (cpu_req_valid_i),
        .cpu_req_addr_i    (cpu_req_addr_i),
        .cpu_req_ready_o   (cpu_req_ready_o),
        .cpu_rsp_valid_o   (cpu_rsp_valid_o),
        .cpu_rsp_data_o    (cpu_rsp_data_o),
        .cpu_rsp_hit_o     (cpu_rsp_hit_o),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_addr_o    (mem_req_addr_o),
        .mem_req_ready_i   (mem_req_ready_i),
        .mem_rsp_valid_i   (mem_rsp_valid_i),
        .mem_rsp_data_i    (mem_rsp_data_i),
        .flush_i           (flush_i),
        .flush_done_o      (flush_done_o),
        .perf_hit_count_o  (perf_hit_count_o),
        .perf_miss_count_o (perf_miss_count_o)
    );

    task automatic value_error(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp_v, act_v);
        assert_errors++;
    endtask

    task automatic test_done(input string name);
        tests_run++;
        $display("Test %0d %s finished, errors so far %0d", tests_run, name,
                 assert_errors + fault_count);
    endtask

    // Hit if either way holds the tag
    function automatic logic model_hit(input logic [31:0] addr);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][addr[7:4]] && ref_tag[w][addr[7:4]] == addr[31:8]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Fill into the pointed way, then move the pointer on
    task automatic model_fill(input logic [31:0] addr);
        logic [3:0] set;
        set = addr[7:4];
        ref_valid[ref_ptr[set]][set] = 1'b1;
        ref_tag[ref_ptr[set]][set] = addr[31:8];
        ref_ptr[set] = ~ref_ptr[set];
    endtask

    // One request, returns on a falling edge with the cache idle
    task automatic fetch(input logic [31:0] addr);
        logic hit;
        int   wait_n;
        hit = model_hit(addr);
        exp_data = {addr[31:2], 2'b00} ^ WORD_MASK;
        exp_line = {addr[31:4], 4'h0};
        cpu_req_valid_i = 1'b1;
        cpu_req_addr_i = addr;
        hit_due = hit;
        miss_pending = !hit;
        // Accepted on the rising edge in between
        @(negedge clk_i);
        cpu_req_valid_i = 1'b0;
        hit_due = 1'b0;
        if (hit) begin
            n_hit = n_hit + 32'd1;
        end else begin
            n_miss = n_miss + 32'd1;
            model_fill(addr);
            wait_n = 0;
            while (!cpu_rsp_valid_o && wait_n < MISS_CYCLES) begin
                @(negedge clk_i);
                wait_n++;
            end
            if (!cpu_rsp_valid_o) begin
                $display("Miss at %h got no response within %0d cycles", addr, MISS_CYCLES);
                fault_count++;
            end
            // Back in idle one cycle after the response
            @(negedge clk_i);
            miss_pending = 1'b0;
        end
    endtask

    // Done is due in the single S_FLUSH cycle
    task automatic flush_cache();
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_due = 1'b1;
        flush_i = 1'b0;
        @(negedge clk_i);
        flush_due = 1'b0;
        for (int s = 0; s < 16; s++) begin
            ref_valid[0][s] = 1'b0;
            ref_valid[1][s] = 1'b0;
        end
    endtask

    // ------------------------------
    // Checks on rising edges
    // ------------------------------
    rsp_valid_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cpu_rsp_valid_o == (hit_due || fill_due))
        else value_error("cpu_rsp_valid_o", 32'(hit_due || fill_due),
                         32'($sampled(cpu_rsp_valid_o)));
    rsp_hit_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cpu_rsp_valid_o |-> cpu_rsp_hit_o == hit_due)
        else value_error("cpu_rsp_hit_o", 32'(hit_due), 32'($sampled(cpu_rsp_hit_o)));
    rsp_data_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cpu_rsp_valid_o |-> cpu_rsp_data_o == exp_data)
        else value_error("cpu_rsp_data_o", exp_data, $sampled(cpu_rsp_data_o));
    // Memory only asked on a miss, for the line base
    mem_req_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o |-> miss_pending)
        else value_error("mem_req_valid_o", 32'd0, 32'($sampled(mem_req_valid_o)));
    mem_addr_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o |-> mem_req_addr_o == exp_line)
        else value_error("mem_req_addr_o", exp_line, $sampled(mem_req_addr_o));
    mem_hold_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(mem_req_valid_o && !mem_req_ready_i) |-> mem_req_valid_o)
        else value_error("mem_req_valid_o", 32'd1, 32'($sampled(mem_req_valid_o)));
    ready_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (after_reset || cpu_req_valid_i) |-> cpu_req_ready_o)
        else value_error("cpu_req_ready_o", 32'd1, 32'($sampled(cpu_req_ready_o)));
    flush_ready_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |-> !cpu_req_ready_o)
        else value_error("cpu_req_ready_o", 32'd0, 32'($sampled(cpu_req_ready_o)));
    flush_done_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_done_o == flush_due)
        else value_error("flush_done_o", 32'(flush_due), 32'($sampled(flush_done_o)));
    hit_count_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cnt_check |-> perf_hit_count_o == n_hit)
        else value_error("perf_hit_count_o", n_hit, $sampled(perf_hit_count_o));
    miss_count_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cnt_check |-> perf_miss_count_o == n_miss)
        else value_error("perf_miss_count_o", n_miss, $sampled(perf_miss_count_o));

    // ------------------------------
    // Memory model
    // ------------------------------
    initial begin : memory_model
        logic [31:0] line;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i = '0;
        fill_due = 1'b0;
        forever begin
            @(negedge clk_i);
            fill_due = 1'b0;
            if (mem_req_valid_o) begin
                line = mem_req_addr_o;
                // Back-pressure for 0 to 3 cycles
                repeat ($urandom_range(3)) @(negedge clk_i);
                mem_req_ready_i = 1'b1;
                @(negedge clk_i);
                mem_req_ready_i = 1'b0;
                for (int k = 0; k < 4; k++) begin
                    repeat ($urandom_range(2)) @(negedge clk_i);
                    mem_rsp_valid_i = 1'b1;
                    mem_rsp_data_i = (line + 32'(4 * k)) ^ WORD_MASK;
                    @(negedge clk_i);
                    mem_rsp_valid_i = 1'b0;
                end
                // Missed word due in the cycle after the last beat
                fill_due = 1'b1;
            end
        end
    end

    initial begin : watchdog
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, run did not complete", RUN_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin : main
        logic [31:0] addr;
        int          r;
        void'($urandom(32'h995d9c35));
        rst_ni = 1'b0;
        cpu_req_valid_i = 1'b0;
        cpu_req_addr_i = '0;
        flush_i = 1'b0;
        hit_due = 1'b0;
        flush_due = 1'b0;
        miss_pending = 1'b0;
        after_reset = 1'b0;
        cnt_check = 1'b0;
        exp_data = '0;
        exp_line = '0;
        n_hit = '0;
        n_miss = '0;
        for (int s = 0; s < 16; s++) begin
            ref_valid[0][s] = 1'b0;
            ref_valid[1][s] = 1'b0;
            ref_tag[0][s] = '0;
            ref_tag[1][s] = '0;
            ref_ptr[s] = 1'b0;
        end

        repeat (8) @(negedge clk_i);
        rst_ni = 1'b1;
        after_reset = 1'b1;
        cnt_check = 1'b1;
        @(negedge clk_i);
        after_reset = 1'b0;
        cnt_check = 1'b0;
        test_done("reset state");

        fetch(32'h0000_1234);
        test_done("cold miss");

        // All four words of the line just filled, byte bits random
        for (int k = 0; k < 4; k++) begin
            fetch(32'h0000_1230 | 32'(k * 4) | 32'($urandom_range(3)));
        end
        test_done("hits");

        // Three lines fight over set 5, the rest spread out
        for (int i = 0; i < RAND_N; i++) begin
            r = $urandom_range(3);
            if (r < 3) begin
                addr = {24'h0000A0 + 24'(r), 4'd5, 4'($urandom)};
            end else begin
                addr = {24'($urandom_range(3)), 4'($urandom), 4'($urandom)};
            end
            fetch(addr);
        end
        test_done("replacement");

        // Both lines resident before the flush
        fetch(32'h0000_1234);
        fetch({24'h0000A0, 4'd5, 4'h8});
        flush_cache();
        fetch(32'h0000_1234);
        fetch({24'h0000A0, 4'd5, 4'h8});
        test_done("flush");

        cnt_check = 1'b1;
        @(negedge clk_i);
        cnt_check = 1'b0;
        test_done("counters");

        @(negedge clk_i);
        $display("Tests run %0d, assertion errors %0d, other failures %0d",
                 tests_run, assert_errors, fault_count);
        if (assert_errors == 0 && fault_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+logic
logic/icache_addr_pkg.sv
logic/icache_ctrl_pkg.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/icache_miss_ctrl.sv
logic/icache_perf_counters.sv
logic/icache_top.sv
verification/icache_tb.sv
